/* all.f */
+incdir+.
ps2_kbd_pkg.sv
ps2_pin_sync.sv
ps2_frame_rx.sv
ps2_code_parser.sv
keyboard_decoder.sv
ps2_keyboard_top.sv
tb_ps2_keyboard_assert.sv
tb_ps2_keyboard.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f all.f --top-module tb_ps2_keyboard -Mdir obj_dir -o sim_ps2

output=$(./obj_dir/sim_ps2 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

/* tb_ps2_keyboard.sv */
`timescale 1ns/1ps
`include "ps2_defs.svh"

module tb_ps2_keyboard;

    import ps2_kbd_pkg::*;

    localparam int HALF_BIT   = 10;
    localparam int PRE_CODES  = 4;
    localparam int MAKE_CODES = 6;
    localparam int SEQ_COUNT  = 40;
    // Worst case is three frames per key sequence plus the fixed tests.
    localparam int MAX_FRAMES  = 3 * PRE_CODES + 4 + 1 + MAKE_CODES + 3 * SEQ_COUNT + 8;
    localparam int CYCLE_LIMIT = MAX_FRAMES * 300 + 20000;

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    logic       ps2_clk = 1'b1;
    logic       ps2_data = 1'b1;
    key_map_t   key_down;
    key_index_t last_change;
    logic       key_valid;
    logic       kbd_ready;
    logic       frame_err;

    // Reference model of parser and decoder.
    key_map_t   m_map = '0;
    logic       m_ready = 1'b0;
    logic       m_ext = 1'b0;
    logic       m_brk = 1'b0;
    key_index_t exp_q[$];
    key_index_t held[$];
    int         exp_errs = 0;

    int         err_seen = 0;
    int         fail_cnt = 0;
    int         other_cnt = 0;
    int         cycles = 0;
    key_map_t   prev_down = '0;

    always #2 clk = ~clk;

    ps2_keyboard_top DUT (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .key_down    (key_down),
        .last_change (last_change),
        .key_valid   (key_valid),
        .kbd_ready   (kbd_ready),
        .frame_err   (frame_err)
    );

    task automatic value_error(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        fail_cnt++;
    endtask

    task automatic other_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        other_cnt++;
    endtask

    task automatic wait_clocks(input int n);
        repeat (n) @(negedge clk);
    endtask

    function automatic ps2_byte_t rand_scan_code();
        ps2_byte_t c;
        c = 8'($urandom_range(255));
        while (c == `PS2_CODE_EXT || c == `PS2_CODE_BRK || c == `PS2_CODE_BAT) begin
            c = 8'($urandom_range(255));
        end
        return c;
    endfunction

    // A damaged frame clears any pending prefix.
    task automatic drop_flags();
        m_ext = 1'b0;
        m_brk = 1'b0;
        exp_errs++;
    endtask

    task automatic apply_model(input ps2_byte_t b);
        key_index_t idx;
        int         i;
        idx = {m_ext, b};
        if (b == `PS2_CODE_EXT) begin
            m_ext = 1'b1;
        end else if (b == `PS2_CODE_BRK) begin
            m_brk = 1'b1;
        end else begin
            if (!m_ready) begin
                m_ready = (b == `PS2_CODE_BAT && !m_ext && !m_brk);
            end else begin
                if (!m_brk && !m_map[idx]) begin
                    held.push_back(idx);
                end
                for (i = held.size() - 1; i >= 0; i--) begin
                    if (m_brk && held[i] == idx) begin
                        held.delete(i);
                    end
                end
                m_map[idx] = ~m_brk;
                exp_q.push_back(idx);
            end
            m_ext = 1'b0;
            m_brk = 1'b0;
        end
    endtask

    // Drives one frame LSB first with data set while the clock is high.
    task automatic send_frame(input ps2_byte_t b, input logic bad_parity, input logic truncate);
        logic [10:0] bits;
        int          nbits;
        int          i;
        bits  = {1'b1, ~(^b) ^ bad_parity, b, 1'b0};
        nbits = truncate ? 5 : 11;
        for (i = 0; i < nbits; i++) begin
            ps2_data = bits[0];
            bits     = bits >> 1;
            wait_clocks(HALF_BIT);
            ps2_clk = 1'b0;
            // The receiver holds the whole byte once the stop bit is clocked.
            if (i == 10) begin
                if (bad_parity) begin
                    drop_flags();
                end else begin
                    apply_model(b);
                end
            end
            wait_clocks(HALF_BIT);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        if (truncate) begin
            drop_flags();
        end
    endtask

    task automatic send_byte(input ps2_byte_t b);
        send_frame(b, 1'b0, 1'b0);
        wait_clocks($urandom_range(60, 20));
    endtask

    task automatic send_key(input key_index_t idx, input logic brk);
        if (idx[8]) begin
            send_byte(`PS2_CODE_EXT);
        end
        if (brk) begin
            send_byte(`PS2_CODE_BRK);
        end
        send_byte(idx[7:0]);
    endtask

    task automatic check_event();
        key_index_t exp_idx;
        if (!key_valid) begin
            other_error("key_down changed without a key_valid pulse");
        end else if (exp_q.size() == 0) begin
            other_error("key_valid pulsed although no key event was expected");
        end else begin
            exp_idx = exp_q.pop_front();
            if (last_change != exp_idx) begin
                value_error($sformatf("last_change %h, expected %h", last_change, exp_idx));
            end
        end
        if (key_down != m_map) begin
            value_error("key_down differs from the model map");
        end
        if (kbd_ready != m_ready) begin
            value_error($sformatf("kbd_ready %b, expected %b", kbd_ready, m_ready));
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            prev_down = '0;
        end else begin
            if (frame_err) begin
                err_seen++;
            end
            if (key_valid || key_down != prev_down) begin
                check_event();
            end
            prev_down = key_down;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        ps2_byte_t code;
        int        kind;
        int        errs_before;
        int        i;
        void'($urandom(14));
        wait_clocks(3);
        rst = 1'b0;
        @(negedge clk);
        if (key_valid || frame_err || kbd_ready || key_down != '0 || last_change != '0) begin
            value_error("outputs not idle after reset");
        end

        // Codes before the self-test byte are ignored.
        for (i = 0; i < PRE_CODES; i++) begin
            send_key({1'($urandom_range(1)), rand_scan_code()}, 1'($urandom_range(1)));
        end
        // A self-test code that carries a prefix does not count.
        send_key({1'b1, `PS2_CODE_BAT}, 1'b0);
        send_key({1'b0, `PS2_CODE_BAT}, 1'b1);
        if (kbd_ready || key_down != '0) begin
            value_error("decoder active before the self-test byte");
        end
        send_byte(`PS2_CODE_BAT);
        if (!kbd_ready || !m_ready) begin
            value_error("kbd_ready low after the self-test byte");
        end

        for (i = 0; i < MAKE_CODES; i++) begin
            send_key({1'b0, rand_scan_code()}, 1'b0);
        end

        // Breaks pick a held key so they clear a set bit.
        for (i = 0; i < SEQ_COUNT; i++) begin
            kind = $urandom_range(2);
            if (kind == 2 && held.size() != 0) begin
                send_key(held[$urandom_range(held.size() - 1)], 1'b1);
            end else begin
                send_key({kind != 0, rand_scan_code()}, 1'b0);
            end
        end

        code = rand_scan_code();
        send_key({1'b0, code}, 1'b0);
        errs_before = err_seen;
        send_byte(8'h00);
        send_frame(rand_scan_code(), 1'b1, 1'b0);
        wait_clocks($urandom_range(60, 20));
        if (err_seen != errs_before + 1) begin
            value_error($sformatf("%0d frame errors on bad parity, expected 1",
                                  err_seen - errs_before));
        end
        send_byte(`PS2_CODE_BRK);
        send_frame(rand_scan_code(), 1'b1, 1'b0);
        wait_clocks($urandom_range(60, 20));
        send_byte(code);
        if (!key_down[{1'b0, code}]) begin
            value_error("break flag survived a frame error");
        end

        errs_before = err_seen;
        send_frame(rand_scan_code(), 1'b0, 1'b1);
        wait_clocks(`PS2_FRAME_TIMEOUT + 100);
        if (err_seen != errs_before + 1) begin
            value_error($sformatf("%0d frame errors on a truncated frame, expected 1",
                                  err_seen - errs_before));
        end
        send_key({1'b0, rand_scan_code()}, 1'b0);

        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        wait_clocks(20);
        if (key_down != m_map || !kbd_ready) begin
            value_error("final key map or ready flag differs from the model");
        end
        if (err_seen != exp_errs) begin
            value_error($sformatf("%0d frame errors seen, expected %0d", err_seen, exp_errs));
        end

        $display("Error counts: %0d value mismatches, %0d other failures",
                 fail_cnt, other_cnt);
        if (fail_cnt == 0 && other_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* tb_ps2_keyboard_assert.sv */
`timescale 1ns/1ps

module tb_ps2_keyboard_assert (
    input logic                  clk,
    input logic                  rst,
    input ps2_kbd_pkg::key_map_t key_down,
    input logic                  key_valid,
    input logic                  kbd_ready,
    input logic                  frame_err
);

    // Key updates only come from a ready decoder.
    valid_when_ready: assert property (@(posedge clk) disable iff (rst)
        key_valid |-> kbd_ready)
        else $error("key_valid high while kbd_ready is low");

    // The map moves only together with key_valid.
    map_stable: assert property (@(posedge clk) disable iff (rst)
        !key_valid |-> $stable(key_down))
        else $error("key_down changed without key_valid");

    valid_single: assert property (@(posedge clk) disable iff (rst)
        key_valid |=> !key_valid)
        else $error("key_valid high for two cycles");

    err_single: assert property (@(posedge clk) disable iff (rst)
        frame_err |=> !frame_err)
        else $error("frame_err high for two cycles");

    // Ready is sticky once the self-test byte was seen.
    ready_sticky: assert property (@(posedge clk) disable iff (rst)
        !$fell(kbd_ready))
        else $error("kbd_ready fell outside reset");

endmodule

bind ps2_keyboard_top tb_ps2_keyboard_assert u_assert (
    .clk       (clk),
    .rst       (rst),
    .key_down  (key_down),
    .key_valid (key_valid),
    .kbd_ready (kbd_ready),
    .frame_err (frame_err)
);

/* ps2_keyboard_top.sv */
`timescale 1ns/1ps

module ps2_keyboard_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ps2_clk,
    input  logic                    ps2_data,
    output ps2_kbd_pkg::key_map_t   key_down,
    output ps2_kbd_pkg::key_index_t last_change,
    output logic                    key_valid,
    output logic                    kbd_ready,
    output logic                    frame_err
);

    import ps2_kbd_pkg::*;

    logic      data_sync;
    logic      clk_fall;
    ps2_byte_t rx_byte;
    logic      byte_valid;
    ps2_code_t code;
    logic      code_valid;

    ps2_pin_sync u_pin_sync (
        .clk       (clk),
        .rst       (rst),
        .ps2_clk   (ps2_clk),
        .ps2_data  (ps2_data),
        .data_sync (data_sync),
        .clk_fall  (clk_fall)
    );

    ps2_frame_rx u_frame_rx (
        .clk        (clk),
        .rst        (rst),
        .data_sync  (data_sync),
        .clk_fall   (clk_fall),
        .rx_byte    (rx_byte),
        .byte_valid (byte_valid),
        .frame_err  (frame_err)
    );

    ps2_code_parser u_code_parser (
        .clk        (clk),
        .rst        (rst),
        .rx_byte    (rx_byte),
        .byte_valid (byte_valid),
        .frame_err  (frame_err),
        .code       (code),
        .code_valid (code_valid)
    );

    keyboard_decoder u_decoder (
        .clk         (clk),
        .rst         (rst),
        .code        (code),
        .code_valid  (code_valid),
        .key_down    (key_down),
        .last_change (last_change),
        .key_valid   (key_valid),
        .kbd_ready   (kbd_ready)
    );

endmodule

/* keyboard_decoder.sv */
`timescale 1ns/1ps
`include "ps2_defs.svh"

module keyboard_decoder (
    input  logic                    clk,
    input  logic                    rst,
    input  ps2_kbd_pkg::ps2_code_t  code,
    input  logic                    code_valid,
    output ps2_kbd_pkg::key_map_t   key_down,
    output ps2_kbd_pkg::key_index_t last_change,
    output logic                    key_valid,
    output logic                    kbd_ready
);

    import ps2_kbd_pkg::*;

    // Self-test byte with no prefix.
    localparam ps2_code_t BAT_CODE = '{extend: 1'b0, brk: 1'b0, code: `PS2_CODE_BAT};

    kbd_state_e state;
    key_index_t key_q;
    logic       brk_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= INIT;
            kbd_ready   <= 1'b0;
            key_valid   <= 1'b0;
            key_down    <= '0;
            last_change <= '0;
        end else begin
            key_valid <= 1'b0;
            case (state)
                INIT: begin
                    // Everything before the self-test result is ignored.
                    if (code_valid && code == BAT_CODE) begin
                        state <= WAIT_CODE;
                    end
                end
                WAIT_CODE: begin
                    kbd_ready <= 1'b1;
                    if (code_valid) begin
                        state <= UPDATE;
                    end
                end
                UPDATE: begin
                    key_down[key_q] <= ~brk_q;
                    last_change     <= key_q;
                    key_valid       <= 1'b1;
                    state           <= WAIT_CODE;
                end
                default: begin
                    state <= INIT;
                end
            endcase
        end
    end

    // Index is the extend flag on top of the scan code.
    always_ff @(posedge clk) begin
        if (state == WAIT_CODE && code_valid) begin
            key_q <= {code.extend, code.code};
            brk_q <= code.brk;
        end
    end

endmodule

/* ps2_code_parser.sv */
`timescale 1ns/1ps
`include "ps2_defs.svh"

module ps2_code_parser (
    input  logic                   clk,
    input  logic                   rst,
    input  ps2_kbd_pkg::ps2_byte_t rx_byte,
    input  logic                   byte_valid,
    input  logic                   frame_err,
    output ps2_kbd_pkg::ps2_code_t code,
    output logic                   code_valid
);

    import ps2_kbd_pkg::*;

    logic ext_pend;
    logic brk_pend;
    logic is_ext;
    logic is_brk;

    assign is_ext = (rx_byte == `PS2_CODE_EXT);
    assign is_brk = (rx_byte == `PS2_CODE_BRK);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ext_pend   <= 1'b0;
            brk_pend   <= 1'b0;
            code_valid <= 1'b0;
        end else begin
            code_valid <= 1'b0;
            if (frame_err) begin
                // Drop any half-received prefix sequence.
                ext_pend <= 1'b0;
                brk_pend <= 1'b0;
            end else if (byte_valid) begin
                if (is_ext) begin
                    ext_pend <= 1'b1;
                end else if (is_brk) begin
                    brk_pend <= 1'b1;
                end else begin
                    code_valid <= 1'b1;
                    ext_pend   <= 1'b0;
                    brk_pend   <= 1'b0;
                end
            end
        end
    end

    // Pack the current flags with each non-prefix byte.
    always_ff @(posedge clk) begin
        if (byte_valid && !is_ext && !is_brk) begin
            code.extend <= ext_pend;
            code.brk    <= brk_pend;
            code.code   <= rx_byte;
        end
    end

endmodule

/* ps2_frame_rx.sv */
`timescale 1ns/1ps
`include "ps2_defs.svh"

module ps2_frame_rx (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  data_sync,
    input  logic                  clk_fall,
    output ps2_kbd_pkg::ps2_byte_t rx_byte,
    output logic                  byte_valid,
    output logic                  frame_err
);

    import ps2_kbd_pkg::*;

    localparam int TO_W = $clog2(`PS2_FRAME_TIMEOUT);
    localparam logic [TO_W-1:0] TO_LAST = TO_W'(`PS2_FRAME_TIMEOUT - 1);

    frame_state_e    state;
    logic [2:0]      bit_cnt;
    logic [TO_W-1:0] idle_cnt;
    logic            parity_ok;
    ps2_byte_t       shift_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            bit_cnt    <= '0;
            idle_cnt   <= '0;
            parity_ok  <= 1'b0;
            byte_valid <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            frame_err  <= 1'b0;

            // Idle counter only runs inside a frame.
            if (clk_fall || state == IDLE) begin
                idle_cnt <= '0;
            end else begin
                idle_cnt <= idle_cnt + 1'b1;
            end

            if (clk_fall) begin
                case (state)
                    IDLE: begin
                        bit_cnt <= '0;
                        if (!data_sync) begin
                            state <= DATA;
                        end else begin
                            frame_err <= 1'b1;
                        end
                    end
                    DATA: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= PARITY;
                        end
                    end
                    PARITY: begin
                        // Odd parity over data and parity bit.
                        parity_ok <= ^{data_sync, shift_q};
                        state     <= STOP;
                    end
                    default: begin
                        state <= IDLE;
                        if (data_sync && parity_ok) begin
                            byte_valid <= 1'b1;
                        end else begin
                            frame_err <= 1'b1;
                        end
                    end
                endcase
            end else if (state != IDLE && idle_cnt == TO_LAST) begin
                state     <= IDLE;
                frame_err <= 1'b1;
            end
        end
    end

    // Data bits arrive LSB first.
    always_ff @(posedge clk) begin
        if (clk_fall && state == DATA) begin
            shift_q <= {data_sync, shift_q[7:1]};
        end
        if (clk_fall && state == STOP && data_sync && parity_ok) begin
            rx_byte <= shift_q;
        end
    end

endmodule

/* ps2_pin_sync.sv */
`timescale 1ns/1ps
`include "ps2_defs.svh"

module ps2_pin_sync (
    input  logic clk,
    input  logic rst,
    input  logic ps2_clk,
    input  logic ps2_data,
    output logic data_sync,
    output logic clk_fall
);

    logic [`PS2_SYNC_STAGES-1:0] clk_sync_q;
    logic [`PS2_SYNC_STAGES-1:0] data_sync_q;
    logic                        clk_prev_q;

    // Both lines idle high, so the chains reset to ones.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clk_sync_q  <= '1;
            data_sync_q <= '1;
            clk_prev_q  <= 1'b1;
        end else begin
            clk_sync_q  <= {clk_sync_q[`PS2_SYNC_STAGES-2:0], ps2_clk};
            data_sync_q <= {data_sync_q[`PS2_SYNC_STAGES-2:0], ps2_data};
            clk_prev_q  <= clk_sync_q[`PS2_SYNC_STAGES-1];
        end
    end

    assign data_sync = data_sync_q[`PS2_SYNC_STAGES-1];

    // High for one cycle when the synchronized clock drops.
    assign clk_fall = clk_prev_q & ~clk_sync_q[`PS2_SYNC_STAGES-1];

endmodule

/* ps2_kbd_pkg.sv */
package ps2_kbd_pkg;

    // One data byte of a PS/2 frame.
    typedef logic [7:0] ps2_byte_t;

    // Key map index with the extend flag on top of the scan code.
    typedef logic [8:0] key_index_t;

    // One bit per key, set while the key is held.
    typedef logic [511:0] key_map_t;

    // Scan code with the prefixes folded in.
    typedef struct packed {
        logic      extend;
        logic      brk;
        ps2_byte_t code;
    } ps2_code_t;

    typedef enum logic [1:0] {
        IDLE,
        DATA,
        PARITY,
        STOP
    } frame_state_e;

    typedef enum logic [1:0] {
        INIT,
        WAIT_CODE,
        UPDATE
    } kbd_state_e;

endpackage

/* ps2_defs.svh */
`ifndef PS2_DEFS_SVH
`define PS2_DEFS_SVH

// Depth of the pin synchronizers.
`define PS2_SYNC_STAGES 2

// System clocks without a PS/2 clock edge before a partial frame is dropped.
`define PS2_FRAME_TIMEOUT 2000

// Self-test pass byte that the keyboard sends after power-up.
`define PS2_CODE_BAT 8'hAA

// Extended key prefix.
`define PS2_CODE_EXT 8'hE0

// Key release prefix.
`define PS2_CODE_BRK 8'hF0

`endif
